// ==== logic/lsu_pipe_pkg.sv ====
package lsu_pipe_pkg;

   // ------------------------------
   // operation type
   // ------------------------------

   // what a packet does once it reaches the dccm or the bus
   typedef enum logic [1:0] {
      LSU_OP_NONE  = 2'b00,   // bubble, no access
      LSU_OP_LOAD  = 2'b01,   // load from dccm or bus
      LSU_OP_STORE = 2'b10,   // store, goes through stbuf
      LSU_OP_DMA   = 2'b11    // dma slave access to dccm
   } lsu_op_e;

   // ------------------------------
   // stage packet
   // ------------------------------

   // one packet per stage: p (decode), d, m, r
   // only valid is control state, op and size are payload
   typedef struct packed {
      logic          valid;   // stage holds a live op
      lsu_op_e       op;      // load, store, dma
      logic [1:0]    size;    // 0 byte, 1 half, 2 word
   } lsu_pkt_t;

   // size encoding as it sits in the packet
   //   2'b00  byte
   //   2'b01  halfword
   //   2'b10  word
   //   2'b11  unused

   // packing order, msb first
   //   [4]    valid
   //   [3:2]  op
   //   [1:0]  size

endpackage

// ==== logic/lsu_clk_pkg.sv ====
package lsu_clk_pkg;

   // ------------------------------
   // status from buffers
   // ------------------------------

   // levels only, no handshake
   typedef struct packed {
      logic dma_dccm_req;              // dma is active on dccm
      logic ldst_stbuf_reqvld_r;       // store allocating into stbuf
      logic stbuf_reqvld_any;          // stbuf draining
      logic stbuf_reqvld_flushed_any;  // stbuf entry of a flushed store
      logic busreq_r;                  // bus request in r
      logic bus_buffer_pend_any;       // bus buffer has a pending entry
      logic bus_buffer_empty_any;      // bus buffer empty
      logic stbuf_empty_any;           // stbuf empty
      logic bus_clk_en;                // bus clock ratio strobe
      logic force_halt;                // high till debug halt taken
   } lsu_buf_status_t;

   // ------------------------------
   // enables and gated clocks
   // ------------------------------

   // one enable per gated clock, field order must match lsu_clk_t
   typedef struct packed {
      logic c1_m;          // m single pulse
      logic c1_r;          // r single pulse
      logic c2_m;          // m double pulse
      logic c2_r;          // r double pulse
      logic store_c1_m;    // store in m
      logic store_c1_r;    // store in r
      logic stbuf_c1;      // store buffer
      logic bus_obuf_c1;   // bus output buffer
      logic bus_ibuf_c1;   // bus input buffer
      logic bus_buf_c1;    // bus buffer entries
      logic busm;          // bus master side
      logic free_c2;       // free double pulse
   } lsu_clken_t;

   typedef struct packed {
      logic c1_m;
      logic c1_r;
      logic c2_m;
      logic c2_r;
      logic store_c1_m;
      logic store_c1_r;
      logic stbuf_c1;
      logic bus_obuf_c1;
      logic bus_ibuf_c1;
      logic bus_buf_c1;
      logic busm;
      logic free_c2;
   } lsu_clk_t;

   // bit positions in the flat vector, free_c2 is bit 0
   localparam int LSU_NUM_CLK      = 12;
   localparam int LSU_CLK_OBUF_IDX = 4;    // bus_obuf_c1
   localparam int LSU_CLK_BUSM_IDX = 1;    // busm

endpackage

// ==== logic/lsu_pkt_stager.sv ====
`timescale 1ns/100ps

module lsu_pkt_stager (
   input  logic                   clk,
   input  logic                   rst_n,
   input  lsu_pipe_pkg::lsu_pkt_t lsu_p,    // decode packet
   input  logic                   flush,    // kills d and m
   output lsu_pipe_pkg::lsu_pkt_t pkt_d,
   output lsu_pipe_pkg::lsu_pkt_t pkt_m,
   output lsu_pipe_pkg::lsu_pkt_t pkt_r
);

   // stage valids, reset
   logic                  d_vld;
   logic                  m_vld;
   logic                  r_vld;

   // stage payload, free running
   lsu_pipe_pkg::lsu_op_e d_op;
   lsu_pipe_pkg::lsu_op_e m_op;
   lsu_pipe_pkg::lsu_op_e r_op;
   logic [1:0]            d_size;
   logic [1:0]            m_size;
   logic [1:0]            r_size;

   // ------------------------------
   // valid shift with flush
   // ------------------------------

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         d_vld <= 1'b0;
         m_vld <= 1'b0;
         r_vld <= 1'b0;
      end else begin
         d_vld <= lsu_p.valid & ~flush;   // younger op dropped on flush
         m_vld <= d_vld & ~flush;
         r_vld <= m_vld;                  // oldest op already committed
      end
   end

   // ------------------------------
   // payload shift
   // ------------------------------

   // moves every cycle, meaning only while the valid is set
   always_ff @(posedge clk) begin
      d_op   <= lsu_p.op;
      d_size <= lsu_p.size;
      m_op   <= d_op;
      m_size <= d_size;
      r_op   <= m_op;
      r_size <= m_size;
   end

   // ------------------------------
   // repack per stage
   // ------------------------------

   assign pkt_d = '{valid: d_vld, op: d_op, size: d_size};
   assign pkt_m = '{valid: m_vld, op: m_op, size: m_size};
   assign pkt_r = '{valid: r_vld, op: r_op, size: r_size};

endmodule

// ==== logic/lsu_clken_gen.sv ====
`timescale 1ns/100ps

module lsu_clken_gen (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          free_c2_clk,   // clocks m/r history
   input  lsu_pipe_pkg::lsu_pkt_t        lsu_p,         // packet in decode
   input  lsu_pipe_pkg::lsu_pkt_t        pkt_d,
   input  lsu_pipe_pkg::lsu_pkt_t        pkt_m,
   input  lsu_pipe_pkg::lsu_pkt_t        pkt_r,
   input  lsu_clk_pkg::lsu_buf_status_t  status,        // buffer levels
   input  logic                          clk_override,  // chicken bit, all on
   output lsu_clk_pkg::lsu_clken_t       clken
);

   // base enables, feed the c2 terms and the history
   logic c1_m_en;
   logic c1_r_en;
   logic free_c1_en;

   // history, one free clock edge old
   logic c1_m_q;
   logic c1_r_q;
   logic free_c1_q;

   // store decode per stage
   logic d_store;
   logic m_store;

   // buffer occupancy, active high
   logic busbuf_busy;
   logic stbuf_busy;

   assign d_store     = (pkt_d.op == lsu_pipe_pkg::LSU_OP_STORE);
   assign m_store     = (pkt_m.op == lsu_pipe_pkg::LSU_OP_STORE);
   assign busbuf_busy = ~status.bus_buffer_empty_any;
   assign stbuf_busy  = ~status.stbuf_empty_any;

   // ------------------------------
   // stage enables
   // ------------------------------

   assign c1_m_en = lsu_p.valid | status.dma_dccm_req | clk_override;
   assign c1_r_en = pkt_m.valid | c1_m_q | clk_override;   // m op moving to r

   // anything in flight or queued keeps the free clock alive
   assign free_c1_en = lsu_p.valid | pkt_d.valid | pkt_m.valid | pkt_r.valid |
                       busbuf_busy | stbuf_busy | clk_override;

   // ------------------------------
   // enable bundle
   // ------------------------------

   always_comb begin
      clken.c1_m       = c1_m_en;
      clken.c1_r       = c1_r_en;
      clken.c2_m       = c1_m_en | c1_m_q | clk_override;   // one extra cycle
      clken.c2_r       = c1_r_en | c1_r_q | clk_override;
      clken.store_c1_m = (c1_m_en & d_store) | clk_override;
      clken.store_c1_r = (c1_r_en & m_store) | clk_override;

      // stbuf allocate, drain or flushed entry
      clken.stbuf_c1   = status.ldst_stbuf_reqvld_r | status.stbuf_reqvld_any |
                         status.stbuf_reqvld_flushed_any | clk_override;

      clken.bus_ibuf_c1 = status.busreq_r | clk_override;
      // bus side ones only on bus clock strobes
      clken.bus_obuf_c1 = (status.bus_buffer_pend_any | status.busreq_r | clk_override) &
                          status.bus_clk_en;
      clken.bus_buf_c1  = busbuf_busy | status.busreq_r | status.force_halt | clk_override;
      clken.busm        = (busbuf_busy | status.busreq_r | clk_override) & status.bus_clk_en;

      clken.free_c2     = free_c1_en | free_c1_q | clk_override;
   end

   // ------------------------------
   // history flops
   // ------------------------------

   // free history on the core clock, so free_c2 can wind down
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         free_c1_q <= 1'b0;
      end else begin
         free_c1_q <= free_c1_en;
      end
   end

   // stage history on the gated free clock, holds while lsu idle
   always_ff @(posedge free_c2_clk or negedge rst_n) begin
      if (!rst_n) begin
         c1_m_q <= 1'b0;
         c1_r_q <= 1'b0;
      end else begin
         c1_m_q <= c1_m_en;
         c1_r_q <= c1_r_en;
      end
   end

endmodule

// ==== logic/lsu_clkgate_bank.sv ====
`timescale 1ns/100ps

module lsu_clkgate_bank #(
   parameter int FPGA_OPTIMIZE = 0   // 1 ties obuf and busm clocks low
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  lsu_clk_pkg::lsu_clken_t clken,
   input  logic                    scan_mode,     // bypass all gates
   output lsu_clk_pkg::lsu_clk_t   lsu_clk,
   output logic                    free_c2_clk    // back to history flops
);

   logic [lsu_clk_pkg::LSU_NUM_CLK-1:0] en_vec;     // flat enables
   logic [lsu_clk_pkg::LSU_NUM_CLK-1:0] gclk_vec;   // flat gated clocks

   assign en_vec = clken;

   // ------------------------------
   // one gate per enable
   // ------------------------------

   for (genvar i = 0; i < lsu_clk_pkg::LSU_NUM_CLK; i++) begin : g_cg
      if ((FPGA_OPTIMIZE != 0) &&
          ((i == lsu_clk_pkg::LSU_CLK_OBUF_IDX) ||
           (i == lsu_clk_pkg::LSU_CLK_BUSM_IDX))) begin : g_tie
         // fpga build, no gate for bus side clocks
         assign gclk_vec[i] = 1'b0;
      end else begin : g_gate
         logic en_lat;   // enable held through the high phase

         // open while clk low, closes on the rising edge
         always_latch begin
            if (!rst_n) begin
               en_lat <= 1'b0;
            end else if (!clk) begin
               en_lat <= en_vec[i] | scan_mode;
            end
         end

         assign gclk_vec[i] = clk & en_lat;   // glitch free, en stable while high
      end
   end

   // ------------------------------
   // back to named clocks
   // ------------------------------

   assign lsu_clk     = lsu_clk_pkg::lsu_clk_t'(gclk_vec);
   assign free_c2_clk = lsu_clk.free_c2;

endmodule

// ==== logic/lsu_clkdomain.sv ====
`timescale 1ns/100ps

module lsu_clkdomain #(
   parameter int FPGA_OPTIMIZE = 0   // passed to the gate bank
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  lsu_pipe_pkg::lsu_pkt_t        lsu_p,          // decode packet
   input  logic                          flush,          // pulse, kills d and m
   input  lsu_clk_pkg::lsu_buf_status_t  status,         // stbuf / bus buffer levels
   input  logic                          clk_override,   // chicken bit
   input  logic                          scan_mode,
   output lsu_clk_pkg::lsu_clk_t         lsu_clk,        // all gated clocks
   output lsu_pipe_pkg::lsu_pkt_t        lsu_pkt_r,      // packet in r
   output logic                          bus_obuf_c1_clken,
   output logic                          busm_clken
);

   lsu_pipe_pkg::lsu_pkt_t   pkt_d;
   lsu_pipe_pkg::lsu_pkt_t   pkt_m;
   lsu_clk_pkg::lsu_clken_t  clken;
   logic                     free_c2_clk;   // gated free clock, loops back

   // ------------------------------
   // stage tracking
   // ------------------------------

   lsu_pkt_stager u_stager (
      .clk   (clk),
      .rst_n (rst_n),
      .lsu_p (lsu_p),
      .flush (flush),
      .pkt_d (pkt_d),
      .pkt_m (pkt_m),
      .pkt_r (lsu_pkt_r)
   );

   // ------------------------------
   // enables
   // ------------------------------

   lsu_clken_gen u_clken_gen (
      .clk          (clk),
      .rst_n        (rst_n),
      .free_c2_clk  (free_c2_clk),
      .lsu_p        (lsu_p),
      .pkt_d        (pkt_d),
      .pkt_m        (pkt_m),
      .pkt_r        (lsu_pkt_r),
      .status       (status),
      .clk_override (clk_override),
      .clken        (clken)
   );

   // ------------------------------
   // clock gates
   // ------------------------------

   lsu_clkgate_bank #(
      .FPGA_OPTIMIZE (FPGA_OPTIMIZE)
   ) u_gate_bank (
      .clk         (clk),
      .rst_n       (rst_n),
      .clken       (clken),
      .scan_mode   (scan_mode),
      .lsu_clk     (lsu_clk),
      .free_c2_clk (free_c2_clk)
   );

   // bus side enables also leave the unit
   assign bus_obuf_c1_clken = clken.bus_obuf_c1;
   assign busm_clken        = clken.busm;

endmodule

// ==== testbench/lsu_clk_checker.sv ====
`timescale 1ns/100ps

module lsu_clk_checker #(
   parameter int FPGA_OPTIMIZE = 0   // must match the dut
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  lsu_pipe_pkg::lsu_pkt_t        lsu_p,
   input  logic                          flush,
   input  lsu_clk_pkg::lsu_buf_status_t  status,
   input  logic                          clk_override,
   input  logic                          scan_mode,
   input  lsu_clk_pkg::lsu_clk_t         lsu_clk,
   input  lsu_pipe_pkg::lsu_pkt_t        lsu_pkt_r,
   input  logic                          bus_obuf_c1_clken,
   input  logic                          busm_clken,
   output int                            err_count,
   output int                            check_count
);

   // model of the stages and history
   lsu_pipe_pkg::lsu_pkt_t  mdl_d;
   lsu_pipe_pkg::lsu_pkt_t  mdl_m;
   lsu_pipe_pkg::lsu_pkt_t  mdl_r;
   logic                    c1_m_q;      // moves only on gated free clock
   logic                    c1_r_q;
   logic                    free_c1_q;   // moves every clk edge
   lsu_clk_pkg::lsu_clk_t   exp_clk;     // gated clocks for this high phase

   initial begin
      err_count   = 0;
      check_count = 0;
   end

   task automatic check_bit(input string name, input logic exp, input logic act);
      check_count++;
      if (act !== exp) begin
         err_count++;
         $display("FAILED t=%0t %s expected %b actual %b", $time, name, exp, act);
      end
   endtask

   // ------------------------------
   // reference model, rising edge
   // ------------------------------

   always @(posedge clk) begin : model_edge
      lsu_clk_pkg::lsu_clken_t en;
      logic                    c1_m;
      logic                    c1_r;
      logic                    free_c1;
      logic                    ovr;

      ovr     = clk_override;
      c1_m    = lsu_p.valid | status.dma_dccm_req | ovr;
      c1_r    = mdl_m.valid | c1_m_q | ovr;
      free_c1 = lsu_p.valid | mdl_d.valid | mdl_m.valid | mdl_r.valid |
                ~status.bus_buffer_empty_any | ~status.stbuf_empty_any | ovr;

      en.c1_m        = c1_m;
      en.c1_r        = c1_r;
      en.c2_m        = c1_m | c1_m_q;   // trailing cycle from history
      en.c2_r        = c1_r | c1_r_q;
      en.store_c1_m  = (c1_m & (mdl_d.op == lsu_pipe_pkg::LSU_OP_STORE)) | ovr;
      en.store_c1_r  = (c1_r & (mdl_m.op == lsu_pipe_pkg::LSU_OP_STORE)) | ovr;
      en.stbuf_c1    = status.ldst_stbuf_reqvld_r | status.stbuf_reqvld_any |
                       status.stbuf_reqvld_flushed_any | ovr;
      en.bus_ibuf_c1 = status.busreq_r | ovr;
      en.bus_obuf_c1 = (status.bus_buffer_pend_any | status.busreq_r | ovr) & status.bus_clk_en;
      en.bus_buf_c1  = ~status.bus_buffer_empty_any | status.busreq_r |
                       status.force_halt | ovr;
      en.busm        = (~status.bus_buffer_empty_any | status.busreq_r | ovr) &
                       status.bus_clk_en;
      en.free_c2     = free_c1 | free_c1_q | ovr;

      // latched enable or scan, nothing while in reset
      exp_clk = lsu_clk_pkg::lsu_clk_t'(en | {lsu_clk_pkg::LSU_NUM_CLK{scan_mode}});
      if (!rst_n) begin
         exp_clk = '0;
      end
      if (FPGA_OPTIMIZE != 0) begin
         exp_clk.bus_obuf_c1 = 1'b0;   // tied low in fpga builds
         exp_clk.busm        = 1'b0;
      end

      if (!rst_n) begin
         c1_m_q    = 1'b0;
         c1_r_q    = 1'b0;
         free_c1_q = 1'b0;
      end else begin
         if (exp_clk.free_c2) begin   // gated free clock ticked here
            c1_m_q = c1_m;
            c1_r_q = c1_r;
         end
         free_c1_q = free_c1;
      end

      // stage shift, payload keeps moving through reset
      mdl_r = mdl_m;
      mdl_m = mdl_d;
      mdl_d = lsu_p;
      if (flush) begin
         mdl_d.valid = 1'b0;   // younger two dropped
         mdl_m.valid = 1'b0;
      end
      if (!rst_n) begin
         mdl_d.valid = 1'b0;
         mdl_m.valid = 1'b0;
         mdl_r.valid = 1'b0;
      end
   end

   // ------------------------------
   // compare, middle of each phase
   // ------------------------------

   always @(posedge clk) begin : high_phase
      logic obuf_exp;
      logic busm_exp;

      #2;
      check_bit("lsu_clk.c1_m", exp_clk.c1_m, lsu_clk.c1_m);
      check_bit("lsu_clk.c1_r", exp_clk.c1_r, lsu_clk.c1_r);
      check_bit("lsu_clk.c2_m", exp_clk.c2_m, lsu_clk.c2_m);
      check_bit("lsu_clk.c2_r", exp_clk.c2_r, lsu_clk.c2_r);
      check_bit("lsu_clk.store_c1_m", exp_clk.store_c1_m, lsu_clk.store_c1_m);
      check_bit("lsu_clk.store_c1_r", exp_clk.store_c1_r, lsu_clk.store_c1_r);
      check_bit("lsu_clk.stbuf_c1", exp_clk.stbuf_c1, lsu_clk.stbuf_c1);
      check_bit("lsu_clk.bus_obuf_c1", exp_clk.bus_obuf_c1, lsu_clk.bus_obuf_c1);
      check_bit("lsu_clk.bus_ibuf_c1", exp_clk.bus_ibuf_c1, lsu_clk.bus_ibuf_c1);
      check_bit("lsu_clk.bus_buf_c1", exp_clk.bus_buf_c1, lsu_clk.bus_buf_c1);
      check_bit("lsu_clk.busm", exp_clk.busm, lsu_clk.busm);
      check_bit("lsu_clk.free_c2", exp_clk.free_c2, lsu_clk.free_c2);

      check_count++;
      if (lsu_pkt_r !== mdl_r) begin
         err_count++;
         $display("FAILED t=%0t lsu_pkt_r expected %b actual %b", $time, mdl_r, lsu_pkt_r);
      end

      // exported enables follow the inputs now on the ports
      obuf_exp = (status.bus_buffer_pend_any | status.busreq_r | clk_override) &
                 status.bus_clk_en;
      busm_exp = (~status.bus_buffer_empty_any | status.busreq_r | clk_override) &
                 status.bus_clk_en;
      check_bit("bus_obuf_c1_clken", obuf_exp, bus_obuf_c1_clken);
      check_bit("busm_clken", busm_exp, busm_clken);
   end

   // every gated clock low while clk is low
   always @(negedge clk) begin : low_phase
      #2;
      check_count++;
      if (lsu_clk !== '0) begin
         err_count++;
         $display("FAILED t=%0t lsu_clk expected %b actual %b", $time,
                  {lsu_clk_pkg::LSU_NUM_CLK{1'b0}}, lsu_clk);
      end
   end

endmodule

// ==== testbench/tb_lsu_clkdomain.sv ====
`timescale 1ns/100ps

module tb_lsu_clkdomain;

   localparam int FPGA_OPT     = 0;
   localparam int RESET_CYCLES = 8;
   localparam int RAND_CYCLES  = 4000;
   localparam int DRAIN_CYCLES = 4;     // let the last packets reach r
   localparam int CYCLE_LIMIT  = RAND_CYCLES + RESET_CYCLES + 200;

   logic                          clk;
   logic                          rst_n;
   lsu_pipe_pkg::lsu_pkt_t        lsu_p;
   logic                          flush;
   lsu_clk_pkg::lsu_buf_status_t  status;
   logic                          clk_override;
   logic                          scan_mode;
   lsu_clk_pkg::lsu_clk_t         lsu_clk;
   lsu_pipe_pkg::lsu_pkt_t        lsu_pkt_r;
   logic                          bus_obuf_c1_clken;
   logic                          busm_clken;

   int          err_count;
   int          check_count;
   int          cycle_count;
   logic [31:0] lfsr;        // stimulus source
   int          idle_left;   // cycles left in the current quiet gap

   lsu_clkdomain #(
      .FPGA_OPTIMIZE (FPGA_OPT)
   ) uut (
      .clk               (clk),
      .rst_n             (rst_n),
      .lsu_p             (lsu_p),
      .flush             (flush),
      .status            (status),
      .clk_override      (clk_override),
      .scan_mode         (scan_mode),
      .lsu_clk           (lsu_clk),
      .lsu_pkt_r         (lsu_pkt_r),
      .bus_obuf_c1_clken (bus_obuf_c1_clken),
      .busm_clken        (busm_clken)
   );

   lsu_clk_checker #(
      .FPGA_OPTIMIZE (FPGA_OPT)
   ) u_checker (
      .clk               (clk),
      .rst_n             (rst_n),
      .lsu_p             (lsu_p),
      .flush             (flush),
      .status            (status),
      .clk_override      (clk_override),
      .scan_mode         (scan_mode),
      .lsu_clk           (lsu_clk),
      .lsu_pkt_r         (lsu_pkt_r),
      .bus_obuf_c1_clken (bus_obuf_c1_clken),
      .busm_clken        (busm_clken),
      .err_count         (err_count),
      .check_count       (check_count)
   );

   // ------------------------------
   // clock and watchdog
   // ------------------------------

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;   // 8 ns period
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < CYCLE_LIMIT) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
      $display("RESULT: FAIL");
      $finish;
   end

   // ------------------------------
   // random source
   // ------------------------------

   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // one lfsr step per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   // ------------------------------
   // per cycle stimulus
   // ------------------------------

   task automatic drive_cycle(input int cyc);
      lsu_pipe_pkg::lsu_pkt_t        pkt;
      lsu_clk_pkg::lsu_buf_status_t  st;
      logic                          quiet;
      logic                          flush_v;
      logic [31:0]                   r;
      int                            win;

      win = cyc % 500;
      if (idle_left > 0) begin
         idle_left--;
         quiet = 1'b1;
      end else if (take_bits(4) == 0) begin
         idle_left = 6 + int'(take_bits(5));   // gap long enough to drain
         quiet     = 1'b1;
      end else begin
         quiet = 1'b0;
      end

      r        = take_bits(4);
      pkt.op   = lsu_pipe_pkg::lsu_op_e'(r[1:0]);   // payload moves even when idle
      pkt.size = r[3:2];
      pkt.valid = 1'b0;
      flush_v   = 1'b0;
      st        = '0;
      st.bus_buffer_empty_any = 1'b1;
      st.stbuf_empty_any      = 1'b1;
      st.bus_clk_en           = (take_bits(1) != 0);

      if (!quiet) begin
         pkt.valid                   = (take_bits(1) != 0);
         flush_v                     = (take_bits(3) == 0);
         st.dma_dccm_req             = (take_bits(3) == 0);
         st.ldst_stbuf_reqvld_r      = (take_bits(2) == 0);
         st.stbuf_reqvld_any         = (take_bits(2) == 0);
         st.stbuf_reqvld_flushed_any = (take_bits(3) == 0);
         st.busreq_r                 = (take_bits(2) == 0);
         st.bus_buffer_pend_any      = (take_bits(2) == 0);
         st.bus_buffer_empty_any     = (take_bits(2) != 0);   // mostly empty
         st.stbuf_empty_any          = (take_bits(2) != 0);
         st.force_halt               = (take_bits(3) == 0);
      end

      lsu_p        <= pkt;
      flush        <= flush_v;
      status       <= st;
      clk_override <= (win >= 120) && (win < 126);   // short chicken bit window
      scan_mode    <= (win >= 320) && (win < 325);
   endtask

   // ------------------------------
   // main sequence
   // ------------------------------

   initial begin
      lfsr         = 32'h4899;
      idle_left    = 0;
      rst_n        <= 1'b0;
      lsu_p        <= '0;
      flush        <= 1'b0;
      status       <= '0;
      clk_override <= 1'b0;
      scan_mode    <= 1'b0;

      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;

      for (int cyc = 0; cyc < RAND_CYCLES; cyc++) begin
         @(posedge clk);
         drive_cycle(cyc);
      end
      repeat (DRAIN_CYCLES) @(posedge clk);
      @(negedge clk);

      if (check_count == 0) begin
         $display("error: the checker made no comparisons");
      end
      $display("checks %0d, errors %0d", check_count, err_count);
      if ((err_count == 0) && (check_count > 0)) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== tb.f ====
logic/lsu_pipe_pkg.sv
logic/lsu_clk_pkg.sv
logic/lsu_pkt_stager.sv
logic/lsu_clken_gen.sv
logic/lsu_clkgate_bank.sv
logic/lsu_clkdomain.sv
testbench/lsu_clk_checker.sv
testbench/tb_lsu_clkdomain.sv
